// File: all.f
+incdir+verification
hw/cps15_load_pkg.sv
hw/cps15_region_decode.sv
hw/cps15_byte_packer.sv
hw/cps15_prog_fsm.sv
hw/cps15_settle_timer.sv
hw/cps15_game_load.sv
verification/tb_cps15_game_load.sv

// File: Bender.yml
package:
  name: cps15_game_load

sources:
  - hw/cps15_load_pkg.sv
  - hw/cps15_region_decode.sv
  - hw/cps15_byte_packer.sv
  - hw/cps15_prog_fsm.sv
  - hw/cps15_settle_timer.sv
  - hw/cps15_game_load.sv
  - target: test
    include_dirs:
      - verification
    files:
      - verification/tb_cps15_game_load.sv

// File: verification/cps15_load_tests.svh
// Directed tests for the ROM download path, included in the testbench top.
// Each task drives the loader side and checks what the DUT answers.

// Sound, PCM and graphics starts in 1 KB units
int bank_units [3] = '{2, 261, 777};

task automatic write_byte(input logic [24:0] addr, input logic [7:0] data);
    ioctl_addr = addr;
    ioctl_data = data;
    ioctl_wr   = 1'b1;
    @(negedge clk);
    ioctl_wr   = 1'b0;
endtask

task automatic wait_write_done(input string what);
    int n;
    n = 0;
    while (prog_we) begin
        @(negedge clk);
        n++;
        if (n > 40) report_timeout(what);
    end
endtask

task automatic start_download();
    check("dwnld_busy", dwnld_busy, 1'b0);
    downloading = 1'b1;
    @(negedge clk);
    check("dwnld_busy", dwnld_busy, 1'b1);
endtask

// Strobes show up one cycle after the write and last one cycle
task automatic header_byte(input int off, input logic [7:0] data,
                           input logic key, input logic cfg, input int idx);
    write_byte(25'(off), data);
    check("kabuki_we", kabuki_we, key);
    check("cfg_we", cfg_we, cfg);
    check("prog_we", prog_we, 1'b0);
    if (key || cfg) begin
        check("prog_data[7:0]", prog_data[7:0], data);
        check("prog_addr[4:0]", prog_addr[4:0], idx);
    end
    @(negedge clk);
    check("kabuki_we", kabuki_we, 1'b0);
    check("cfg_we", cfg_we, 1'b0);
endtask

task automatic header_strobes();
    logic [7:0] d;
    for (int i = 0; i < KABUKI_LEN; i++) begin
        d = 8'($random(seed));
        header_byte(KABUKI_BASE + i, d, 1'b1, 1'b0, i);
    end
    for (int i = 0; i < CFG_LEN; i++) begin
        d = 8'($random(seed));
        header_byte(CFG_BASE + i, d, 1'b0, 1'b1, i);
    end
endtask

// One full ROM word at word offset w
task automatic rom_word(input int w, input logic [15:0] data,
                        input logic [1:0] ba, input int rel);
    int count;
    count = wr_data.size();
    write_byte(25'(HEADER_LEN + 2 * w), data[7:0]);
    @(negedge clk);
    write_byte(25'(HEADER_LEN + 2 * w + 1), data[15:8]);
    check("prog_we", prog_we, 1'b1);
    check("dwnld_busy", dwnld_busy, 1'b1);
    wait_write_done("prog_we to fall after a ROM word");
    check("write count", wr_data.size(), count + 1);
    check("prog_data", wr_data[$], data);
    check("prog_mask", wr_mask[$], 2'b00);
    check("prog_ba", wr_ba[$], ba);
    check("prog_addr", wr_addr[$], rel);
endtask

task automatic bank_regions();
    logic [1:0] codes [4];
    int         b;
    int         prev;
    codes = '{BA_MAIN, BA_SND, BA_PCM, BA_GFX};
    for (int i = 0; i < 3; i++) begin
        header_byte(2 * i, bank_units[i][7:0], 1'b0, 1'b0, 0);
        header_byte(2 * i + 1, bank_units[i][15:8], 1'b0, 1'b0, 0);
    end
    rom_word(0, 16'($random(seed)), BA_MAIN, 0);
    // Last word below each start and the first word at it
    for (int i = 1; i < 4; i++) begin
        b    = bank_units[i - 1] * START_UNIT_WORDS;
        prev = (i == 1) ? 0 : bank_units[i - 2] * START_UNIT_WORDS;
        rom_word(b - 1, 16'($random(seed)), codes[i - 1], b - 1 - prev);
        rom_word(b, 16'($random(seed)), codes[i], 0);
    end
endtask

task automatic word_packing();
    int base;
    base = bank_units[2] * START_UNIT_WORDS;
    for (int i = 0; i < 24; i++) begin
        rom_word(base + 200 + i, 16'($random(seed)), BA_GFX, 200 + i);
    end
endtask

// Download ends on an even byte, then the settle period runs
task automatic tail_and_busy();
    logic [7:0] d;
    int         w;
    int         count;
    int         n;
    w     = bank_units[2] * START_UNIT_WORDS + 300;
    d     = 8'($random(seed));
    count = wr_data.size();
    write_byte(25'(HEADER_LEN + 2 * w), d);
    check("prog_we", prog_we, 1'b0);
    downloading = 1'b0;
    n = 0;
    while (!prog_we) begin
        @(negedge clk);
        n++;
        if (n > 10) report_timeout("the flush write after downloading fell");
    end
    check("dwnld_busy", dwnld_busy, 1'b1);
    wait_write_done("prog_we to fall after the flush write");
    check("write count", wr_data.size(), count + 1);
    check("prog_mask", wr_mask[$], 2'b10);
    check("prog_data[7:0]", wr_data[$][7:0], d);
    check("prog_ba", wr_ba[$], BA_GFX);
    check("prog_addr", wr_addr[$], 300);
    // Timer starts one cycle after the write ends
    n = 0;
    while (dwnld_busy) begin
        @(negedge clk);
        n++;
        if (n > 4 * SETTLE_CYCLES) report_timeout("dwnld_busy to fall");
    end
    check("settle cycles", n, SETTLE_CYCLES + 1);
endtask

// File: verification/tb_cps15_game_load.sv
// Testbench for the ROM download path of the CPS 1.5 game core.
// Loader bytes are driven on the falling edge. An SDRAM responder answers
// prog_we with a randomly delayed prog_rdy and records every write.
// The directed tests come from the included test file.
`timescale 1ns/1ps

module tb_cps15_game_load;
    import cps15_load_pkg::*;

    logic        clk;
    logic        rst_n;
    logic        downloading;
    logic [24:0] ioctl_addr;
    logic [ 7:0] ioctl_data;
    logic        ioctl_wr;
    logic        prog_rdy;
    logic        dwnld_busy;
    logic [21:0] prog_addr;
    logic [15:0] prog_data;
    logic [ 1:0] prog_mask;
    logic [ 1:0] prog_ba;
    logic        prog_we;
    logic        kabuki_we;
    logic        cfg_we;

    integer      seed = 32'h62f2_b6a7;

    // Writes seen by the SDRAM side, in order
    logic [21:0] wr_addr [$];
    logic [15:0] wr_data [$];
    logic [ 1:0] wr_mask [$];
    logic [ 1:0] wr_ba   [$];

    cps15_game_load u_cps15_game_load (
        .clk         ( clk         ),
        .rst_n       ( rst_n       ),
        .downloading ( downloading ),
        .ioctl_addr  ( ioctl_addr  ),
        .ioctl_data  ( ioctl_data  ),
        .ioctl_wr    ( ioctl_wr    ),
        .prog_rdy    ( prog_rdy    ),
        .dwnld_busy  ( dwnld_busy  ),
        .prog_addr   ( prog_addr   ),
        .prog_data   ( prog_data   ),
        .prog_mask   ( prog_mask   ),
        .prog_ba     ( prog_ba     ),
        .prog_we     ( prog_we     ),
        .kabuki_we   ( kabuki_we   ),
        .cfg_we      ( cfg_we      )
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("MISMATCH %s: got 0x%0h, expected 0x%0h", name, got, exp);
            $display("Finished with errors");
            $fatal(1, "value check failed");
        end
    endtask

    task automatic report_timeout(input string what);
        $display("Timed out waiting for %s", what);
        $display("Finished with errors");
        $fatal(1, "wait timed out");
    endtask

    // SDRAM side with 0 to 7 cycles of latency
    initial begin : sdram_responder
        int          delay;
        logic [21:0] a;
        logic [15:0] d;
        logic [ 1:0] m;
        logic [ 1:0] b;
        prog_rdy = 1'b0;
        forever begin
            @(negedge clk);
            if (prog_we) begin
                a = prog_addr;
                d = prog_data;
                m = prog_mask;
                b = prog_ba;
                delay = $unsigned($random(seed)) % 8;
                repeat (delay) begin
                    @(negedge clk);
                    check("prog_we held", prog_we, 1'b1);
                    check("prog_addr held", prog_addr, a);
                    check("prog_data held", prog_data, d);
                    check("prog_mask held", prog_mask, m);
                    check("prog_ba held", prog_ba, b);
                end
                wr_addr.push_back(a);
                wr_data.push_back(d);
                wr_mask.push_back(m);
                wr_ba.push_back(b);
                prog_rdy = 1'b1;
                @(negedge clk);
                prog_rdy = 1'b0;
            end
        end
    end

    `include "cps15_load_tests.svh"

    initial begin
        rst_n       = 1'b0;
        downloading = 1'b0;
        ioctl_addr  = '0;
        ioctl_data  = '0;
        ioctl_wr    = 1'b0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        check("prog_we", prog_we, 1'b0);
        check("kabuki_we", kabuki_we, 1'b0);
        check("cfg_we", cfg_we, 1'b0);
        check("dwnld_busy", dwnld_busy, 1'b0);

        start_download();
        header_strobes();
        bank_regions();
        word_packing();
        tail_and_busy();

        $display("Finished with no errors");
        $finish;
    end

endmodule

// File: hw/cps15_game_load.sv
// ROM download path of the CPS 1.5 game top level.
// Turns the loader byte stream into SDRAM programming writes and raises
// the kabuki key and CPS-B configuration strobes. While the header is
// loading, prog_data and prog_addr carry the header byte and its index.
`timescale 1ns/1ps

module cps15_game_load (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        downloading,
    input  logic [24:0] ioctl_addr,
    input  logic [ 7:0] ioctl_data,
    input  logic        ioctl_wr,
    input  logic        prog_rdy,
    output logic        dwnld_busy,
    output logic [21:0] prog_addr,
    output logic [15:0] prog_data,
    output logic [ 1:0] prog_mask,
    output logic [ 1:0] prog_ba,
    output logic        prog_we,
    output logic        kabuki_we,
    output logic        cfg_we
);

    logic        hdr_hit;
    logic        rom_hit;
    logic        rom_byte_sel;
    logic [21:0] word_addr;
    logic [ 1:0] word_ba;
    logic [ 4:0] cfg_index;
    logic [ 7:0] cfg_byte;
    logic        word_valid;
    logic [15:0] word_data;
    logic [ 1:0] word_mask;
    logic        pending;
    logic        flush;
    logic        timer_start;
    logic        timer_done;
    logic [21:0] seq_addr;
    logic [15:0] seq_data;
    logic        show_hdr;

    // Header byte goes out while no SDRAM write is in progress
    assign show_hdr  = hdr_hit & ~prog_we;
    assign prog_addr = show_hdr ? {17'd0, cfg_index} : seq_addr;
    assign prog_data = show_hdr ? {8'h00, cfg_byte} : seq_data;

    cps15_region_decode u_decode (
        .clk          ( clk          ),
        .rst_n        ( rst_n        ),
        .ioctl_addr   ( ioctl_addr   ),
        .ioctl_data   ( ioctl_data   ),
        .ioctl_wr     ( ioctl_wr     ),
        .hdr_hit      ( hdr_hit      ),
        .rom_hit      ( rom_hit      ),
        .rom_byte_sel ( rom_byte_sel ),
        .word_addr    ( word_addr    ),
        .word_ba      ( word_ba      ),
        .kabuki_we    ( kabuki_we    ),
        .cfg_we       ( cfg_we       ),
        .cfg_index    ( cfg_index    ),
        .cfg_byte     ( cfg_byte     )
    );

    cps15_byte_packer u_packer (
        .clk          ( clk          ),
        .rst_n        ( rst_n        ),
        .rom_hit      ( rom_hit      ),
        .rom_byte_sel ( rom_byte_sel ),
        .ioctl_data   ( ioctl_data   ),
        .ioctl_wr     ( ioctl_wr     ),
        .flush        ( flush        ),
        .word_valid   ( word_valid   ),
        .word_data    ( word_data    ),
        .word_mask    ( word_mask    ),
        .pending      ( pending      )
    );

    cps15_prog_fsm u_fsm (
        .clk          ( clk          ),
        .rst_n        ( rst_n        ),
        .downloading  ( downloading  ),
        .word_valid   ( word_valid   ),
        .word_data    ( word_data    ),
        .word_mask    ( word_mask    ),
        .word_addr    ( word_addr    ),
        .word_ba      ( word_ba      ),
        .pending      ( pending      ),
        .prog_rdy     ( prog_rdy     ),
        .timer_done   ( timer_done   ),
        .flush        ( flush        ),
        .timer_start  ( timer_start  ),
        .prog_addr    ( seq_addr     ),
        .prog_data    ( seq_data     ),
        .prog_mask    ( prog_mask    ),
        .prog_ba      ( prog_ba      ),
        .prog_we      ( prog_we      ),
        .dwnld_busy   ( dwnld_busy   )
    );

    cps15_settle_timer u_timer (
        .clk          ( clk          ),
        .rst_n        ( rst_n        ),
        .timer_start  ( timer_start  ),
        .timer_done   ( timer_done   )
    );

endmodule

// File: hw/cps15_settle_timer.sv
// Settle counter started by the write sequencer at the end of a download.
// timer_done pulses once, SETTLE_CYCLES edges after timer_start is seen.
`timescale 1ns/1ps

module cps15_settle_timer (
    input  logic clk,
    input  logic rst_n,
    input  logic timer_start,
    output logic timer_done
);
    import cps15_load_pkg::*;

    logic [SETTLE_W-1:0] cnt;
    logic                running;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt        <= '0;
            running    <= 1'b0;
            timer_done <= 1'b0;
        end else begin
            timer_done <= running && cnt == SETTLE_W'(1);
            if (timer_start) begin
                cnt     <= SETTLE_W'(SETTLE_CYCLES - 1);
                running <= 1'b1;
            end else if (running) begin
                cnt <= cnt - 1'b1;
                // Stops on reaching zero
                if (cnt == SETTLE_W'(1)) begin
                    running <= 1'b0;
                end
            end
        end
    end

endmodule

// File: hw/cps15_prog_fsm.sv
// Write sequencer for SDRAM programming.
// Each packed word is latched onto the prog outputs and prog_we is held
// until prog_rdy. When the download ends, a held even byte is flushed,
// then the settle timer runs before dwnld_busy is released.
`timescale 1ns/1ps

module cps15_prog_fsm (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        downloading,
    input  logic        word_valid,
    input  logic [15:0] word_data,
    input  logic [ 1:0] word_mask,
    input  logic [21:0] word_addr,
    input  logic [ 1:0] word_ba,
    input  logic        pending,
    input  logic        prog_rdy,
    input  logic        timer_done,
    output logic        flush,
    output logic        timer_start,
    output logic [21:0] prog_addr,
    output logic [15:0] prog_data,
    output logic [ 1:0] prog_mask,
    output logic [ 1:0] prog_ba,
    output logic        prog_we,
    output logic        dwnld_busy
);
    import cps15_load_pkg::*;

    logic [2:0] state;
    logic       take_word;

    assign flush     = state == ST_FLUSH;
    assign take_word = word_valid && (state == ST_LOAD || state == ST_FLUSH);

    // Download over and nothing left to write
    assign timer_start = state == ST_LOAD && !downloading && !word_valid && !pending;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= ST_IDLE;
            prog_we    <= 1'b0;
            dwnld_busy <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (downloading) begin
                        state      <= ST_LOAD;
                        dwnld_busy <= 1'b1;
                    end
                end
                ST_LOAD: begin
                    if (word_valid) begin
                        prog_we <= 1'b1;
                        state   <= ST_WRITE;
                    end else if (!downloading) begin
                        state <= pending ? ST_FLUSH : ST_SETTLE;
                    end
                end
                ST_FLUSH: begin
                    if (word_valid) begin
                        prog_we <= 1'b1;
                        state   <= ST_WRITE;
                    end else begin
                        state <= ST_LOAD;
                    end
                end
                ST_WRITE: begin
                    // Held for as long as the SDRAM takes
                    if (prog_rdy) begin
                        prog_we <= 1'b0;
                        state   <= ST_LOAD;
                    end
                end
                ST_SETTLE: begin
                    if (downloading) begin
                        state <= ST_LOAD;
                    end else if (timer_done) begin
                        dwnld_busy <= 1'b0;
                        state      <= ST_IDLE;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (take_word) begin
            prog_addr <= word_addr;
            prog_data <= word_data;
            prog_mask <= word_mask;
            prog_ba   <= word_ba;
        end
    end

endmodule

// File: hw/cps15_byte_packer.sv
// Pairs download bytes into 16-bit SDRAM words.
// The even byte waits in a holding register; the odd byte completes the
// word. A flush sends a lone even byte with the high half masked.
`timescale 1ns/1ps

module cps15_byte_packer (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        rom_hit,
    input  logic        rom_byte_sel,
    input  logic [ 7:0] ioctl_data,
    input  logic        ioctl_wr,
    input  logic        flush,
    output logic        word_valid,
    output logic [15:0] word_data,
    output logic [ 1:0] word_mask,
    output logic        pending
);

    logic [7:0] hold;
    logic       even_wr;
    logic       odd_wr;

    assign even_wr    = ioctl_wr & rom_hit & ~rom_byte_sel;
    assign odd_wr     = ioctl_wr & rom_hit & rom_byte_sel;
    assign word_valid = odd_wr | (flush & pending);

    always_comb begin
        if (odd_wr) begin
            word_data = {ioctl_data, hold};
            // Low half masked if no even byte came first
            word_mask = {1'b0, ~pending};
        end else begin
            word_data = {8'h00, hold};
            word_mask = 2'b10;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pending <= 1'b0;
        end else if (even_wr) begin
            pending <= 1'b1;
        end else if (odd_wr || flush) begin
            pending <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (even_wr) begin
            hold <= ioctl_data;
        end
    end

endmodule

// File: hw/cps15_region_decode.sv
// Address decoder for the download stream.
// Header bytes fill the bank start registers or pulse the kabuki and CPS-B
// strobes with their index. ROM bytes are mapped to an SDRAM bank and a
// word address relative to the start of that bank.
`timescale 1ns/1ps

module cps15_region_decode (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [24:0] ioctl_addr,
    input  logic [ 7:0] ioctl_data,
    input  logic        ioctl_wr,
    output logic        hdr_hit,
    output logic        rom_hit,
    output logic        rom_byte_sel,
    output logic [21:0] word_addr,
    output logic [ 1:0] word_ba,
    output logic        kabuki_we,
    output logic        cfg_we,
    output logic [ 4:0] cfg_index,
    output logic [ 7:0] cfg_byte
);
    import cps15_load_pkg::*;

    load_addr_u  addr;
    logic        in_header;
    logic [ 5:0] hdr_off;
    logic [ 5:0] key_idx;
    logic [ 5:0] cfg_idx;
    logic        key_sel;
    logic        cfg_sel;
    logic        bank_sel;
    logic        rom_wr;
    logic [15:0] bank_start [3];
    logic [24:0] snd_words;
    logic [24:0] pcm_words;
    logic [24:0] gfx_words;
    logic [24:0] word_off;
    logic [24:0] rel_addr;
    logic [ 1:0] cur_ba;
    logic [21:0] addr_q;
    logic [ 1:0] ba_q;

    assign addr      = ioctl_addr;
    assign in_header = addr.hdr.upper == '0;

    // Header slots
    assign hdr_off  = {addr.hdr.field, addr.hdr.entry};
    assign key_idx  = hdr_off - 6'(KABUKI_BASE);
    assign cfg_idx  = hdr_off - 6'(CFG_BASE);
    assign key_sel  = in_header && hdr_off >= KABUKI_BASE && key_idx < KABUKI_LEN;
    assign cfg_sel  = in_header && hdr_off >= CFG_BASE && cfg_idx < CFG_LEN;
    assign bank_sel = in_header && addr.hdr.field == 2'd0 && addr.hdr.entry < BANK_BYTES;

    // ROM side
    assign rom_hit      = ~in_header;
    assign rom_byte_sel = addr.rom.byte_sel;
    assign rom_wr       = ioctl_wr & rom_hit;
    assign word_off     = {1'b0, addr.rom.word} - 25'(HEADER_LEN / 2);

    assign snd_words = 25'(bank_start[0]) * 25'(START_UNIT_WORDS);
    assign pcm_words = 25'(bank_start[1]) * 25'(START_UNIT_WORDS);
    assign gfx_words = 25'(bank_start[2]) * 25'(START_UNIT_WORDS);

    // Highest start not above the offset wins
    always_comb begin
        if (word_off >= gfx_words) begin
            cur_ba   = BA_GFX;
            rel_addr = word_off - gfx_words;
        end else if (word_off >= pcm_words) begin
            cur_ba   = BA_PCM;
            rel_addr = word_off - pcm_words;
        end else if (word_off >= snd_words) begin
            cur_ba   = BA_SND;
            rel_addr = word_off - snd_words;
        end else begin
            cur_ba   = BA_MAIN;
            rel_addr = word_off;
        end
    end

    // Last ROM word address stays visible for the tail flush
    assign word_addr = rom_wr ? rel_addr[21:0] : addr_q;
    assign word_ba   = rom_wr ? cur_ba : ba_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hdr_hit       <= 1'b0;
            kabuki_we     <= 1'b0;
            cfg_we        <= 1'b0;
            bank_start[0] <= '0;
            bank_start[1] <= '0;
            bank_start[2] <= '0;
        end else begin
            kabuki_we <= ioctl_wr & key_sel;
            cfg_we    <= ioctl_wr & cfg_sel;
            if (ioctl_wr) begin
                hdr_hit <= in_header;
            end
            // Little endian, odd entry is the high byte
            if (ioctl_wr && bank_sel) begin
                if (addr.hdr.entry[0]) begin
                    bank_start[addr.hdr.entry[2:1]][15:8] <= ioctl_data;
                end else begin
                    bank_start[addr.hdr.entry[2:1]][7:0] <= ioctl_data;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ioctl_wr && in_header) begin
            cfg_byte  <= ioctl_data;
            cfg_index <= key_sel ? key_idx[4:0] : cfg_idx[4:0];
        end
        if (rom_wr) begin
            addr_q <= rel_addr[21:0];
            ba_q   <= cur_ba;
        end
    end

endmodule

// File: hw/cps15_load_pkg.sv
// Constants and the download address view shared by the ROM load path.
// Each module imports this package inside its body when it needs it.
package cps15_load_pkg;

    // Header layout, in bytes from the start of the download
    localparam int HEADER_LEN  = 64;
    localparam int BANK_BYTES  = 6;
    localparam int KABUKI_BASE = 16;
    localparam int KABUKI_LEN  = 11;
    localparam int CFG_BASE    = 32;
    localparam int CFG_LEN     = 24;

    // One bank start unit is 1 KB of ROM
    localparam int START_UNIT_WORDS = 512;

    // Busy hold-off after the download ends
    localparam int SETTLE_CYCLES = 16;
    localparam int SETTLE_W      = $clog2(SETTLE_CYCLES);

    // SDRAM bank codes
    localparam logic [1:0] BA_MAIN = 2'd0;
    localparam logic [1:0] BA_SND  = 2'd1;
    localparam logic [1:0] BA_PCM  = 2'd2;
    localparam logic [1:0] BA_GFX  = 2'd3;

    // Write sequencer states
    localparam logic [2:0] ST_IDLE   = 3'd0;
    localparam logic [2:0] ST_LOAD   = 3'd1;
    localparam logic [2:0] ST_WRITE  = 3'd2;
    localparam logic [2:0] ST_FLUSH  = 3'd3;
    localparam logic [2:0] ST_SETTLE = 3'd4;

    // Loader byte address, read as header slot or as ROM word
    typedef union packed {
        struct packed {
            logic [18:0] upper;
            logic [ 1:0] field;
            logic [ 3:0] entry;
        } hdr;
        struct packed {
            logic [23:0] word;
            logic        byte_sel;
        } rom;
    } load_addr_u;

endpackage
